/* hdl/tile_defs.svh */
`ifndef TILE_DEFS_SVH
`define TILE_DEFS_SVH

// Port widths
`define TILE_ADDR_W    32  // Byte address, both ports
`define TILE_DATA_W    32  // Data word
`define TILE_LEN_W     8   // Vector length field

// Command layout
`define TILE_CMD_WORDS 4   // Words per command

// Fields of command word 0
`define TILE_OP_MSB    31
`define TILE_OP_LSB    28
`define TILE_LEN_MSB   27
`define TILE_LEN_LSB   20

// Exit code sits in the low bits of an END command
`define TILE_EXIT_W    16

`endif

/* hdl/tile_pkg.sv */
`include "tile_defs.svh"

package tile_pkg;

  // Vector types with a meaning
  typedef logic [`TILE_ADDR_W-1:0] addr_t;   // Byte address
  typedef logic [`TILE_DATA_W-1:0] word_t;   // Data word
  typedef logic [`TILE_LEN_W-1:0]  len_t;    // Element count or index
  typedef logic [`TILE_EXIT_W-1:0] exit_t;   // Exit code
  typedef logic [63:0]             cycle_t;  // Cycle count

  // Command opcodes, any other encoding is illegal
  typedef enum logic [`TILE_OP_MSB-`TILE_OP_LSB:0] {
    OP_DOT  = 4'd1,   // Sum of element products
    OP_VADD = 4'd2,   // Element-wise sum
    OP_END  = 4'd15   // Stop with exit code
  } opcode_e;

  // Control FSM states
  typedef enum logic [2:0] {
    IDLE,    // Waiting for fetch enable
    FETCH,   // Four-word command read
    DECODE,  // Issue of the next element
    RD_A,
    RD_B,
    EXEC,    // Accumulator update
    WR,      // Result write
    DONE     // Parked after END
  } state_e;

endpackage

/* hdl/tile_ctrl_fsm.sv */
`timescale 1ns/10ps

`include "tile_defs.svh"

module tile_ctrl_fsm import tile_pkg::*; (
  input  logic    clk,
  input  logic    rst_n_i,
  input  logic    fetch_enable_i,
  input  logic    fetch_done_i,
  input  logic    op_done_i,
  input  logic    last_elem_i,
  input  opcode_e opcode_i,
  input  exit_t   exit_i,
  output logic    fetch_start_o,
  output logic    rd_a_start_o,
  output logic    rd_b_start_o,
  output logic    wr_start_o,
  output logic    acc_clr_o,
  output logic    acc_en_o,
  output logic    cnt_clr_o,
  output logic    cnt_inc_o,
  output logic    busy_o,
  output logic    core_sleep_o,
  output logic    eoc_o,
  output exit_t   exit_code_o
);

  localparam exit_t exit_illegal = 16'hDEAD;  // Reported for unknown opcodes

  state_e state_q, state_d;
  logic   is_vec_op;  // DOT or VADD
  logic   eoc_q;
  exit_t  exit_q;

  assign is_vec_op = (opcode_i == OP_DOT) || (opcode_i == OP_VADD);

  always_comb begin
    state_d       = state_q;
    fetch_start_o = 1'b0;
    rd_a_start_o  = 1'b0;
    rd_b_start_o  = 1'b0;
    wr_start_o    = 1'b0;
    acc_clr_o     = 1'b0;
    acc_en_o      = 1'b0;
    cnt_clr_o     = 1'b0;
    cnt_inc_o     = 1'b0;
    case (state_q)
      IDLE: if (fetch_enable_i) begin
        fetch_start_o = 1'b1;
        state_d       = FETCH;
      end
      FETCH: if (fetch_done_i) begin
        if (is_vec_op) begin
          cnt_clr_o = 1'b1;  // Fresh element index
          acc_clr_o = 1'b1;
          state_d   = DECODE;
        end else begin
          state_d = DONE;    // END or illegal
        end
      end
      DECODE: begin
        rd_a_start_o = 1'b1;
        state_d      = RD_A;
      end
      RD_A: if (op_done_i) begin
        rd_b_start_o = 1'b1;  // B follows A directly
        state_d      = RD_B;
      end
      RD_B: if (op_done_i) state_d = EXEC;
      EXEC: begin
        acc_en_o = 1'b1;
        if (opcode_i == OP_VADD) begin
          wr_start_o = 1'b1;  // One write per element
          state_d    = WR;
        end else if (last_elem_i) begin
          // Index back to zero so the LSU writes at the bare destination base
          cnt_clr_o  = 1'b1;
          wr_start_o = 1'b1;
          state_d    = WR;
        end else begin
          cnt_inc_o = 1'b1;
          state_d   = DECODE;
        end
      end
      WR: if (op_done_i) begin
        if (opcode_i == OP_DOT || last_elem_i) begin
          fetch_start_o = 1'b1;  // Next command
          state_d       = FETCH;
        end else begin
          cnt_inc_o = 1'b1;
          state_d   = DECODE;
        end
      end
      DONE: state_d = DONE;  // Parked until reset
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      eoc_q   <= 1'b0;
      exit_q  <= '0;
    end else begin
      state_q <= state_d;
      // Exit code latched as the stopping command finishes fetching
      if (state_q == FETCH && fetch_done_i && !is_vec_op) begin
        eoc_q  <= 1'b1;
        exit_q <= (opcode_i == OP_END) ? exit_i : exit_illegal;
      end
    end
  end

  assign busy_o       = (state_q != IDLE) && (state_q != DONE);
  assign core_sleep_o = (state_q == IDLE);
  assign eoc_o        = eoc_q;
  assign exit_code_o  = exit_q;

endmodule

/* hdl/tile_step_counter.sv */
`timescale 1ns/10ps

`include "tile_defs.svh"

module tile_step_counter import tile_pkg::*; (
  input  logic   clk,
  input  logic   rst_n_i,
  input  logic   cnt_clr_i,
  input  logic   cnt_inc_i,
  input  len_t   len_i,
  output len_t   idx_o,
  output logic   last_elem_o,
  output cycle_t mcycle_o
);

  len_t   idx_q;
  len_t   last_idx;  // Index of the final element
  cycle_t mcycle_q;

  // Zero length runs like length one
  assign last_idx = (len_i == '0) ? '0 : len_i - 1'b1;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      idx_q <= '0;
    end else if (cnt_clr_i) begin
      idx_q <= '0;  // Clear wins over increment
    end else if (cnt_inc_i) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  // Free-running from reset
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mcycle_q <= '0;
    end else begin
      mcycle_q <= mcycle_q + 1'b1;
    end
  end

  assign idx_o       = idx_q;
  assign last_elem_o = (idx_q == last_idx);
  assign mcycle_o    = mcycle_q;

endmodule

/* hdl/tile_fetch_unit.sv */
`timescale 1ns/10ps

`include "tile_defs.svh"

module tile_fetch_unit import tile_pkg::*; (
  input  logic    clk,
  input  logic    rst_n_i,
  input  addr_t   boot_addr_i,
  input  logic    fetch_start_i,
  output logic    instr_req_o,
  output addr_t   instr_addr_o,
  input  logic    instr_gnt_i,
  input  logic    instr_rvalid_i,
  input  word_t   instr_rdata_i,
  output logic    fetch_done_o,
  output opcode_e opcode_o,
  output len_t    len_o,
  output addr_t   a_base_o,
  output addr_t   b_base_o,
  output addr_t   d_base_o,
  output exit_t   exit_o
);

  localparam int cnt_w = $clog2(`TILE_CMD_WORDS);

  addr_t            pc_q;
  logic             booted_q;   // PC taken from boot address
  logic             req_q;
  logic             wait_q;     // Read granted, data pending
  logic             done_q;
  logic [cnt_w-1:0] word_cnt_q;
  word_t            cmd_q [`TILE_CMD_WORDS];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q       <= '0;
      booted_q   <= 1'b0;
      req_q      <= 1'b0;
      wait_q     <= 1'b0;
      done_q     <= 1'b0;
      word_cnt_q <= '0;
    end else begin
      done_q <= 1'b0;  // Single-cycle pulse
      if (fetch_start_i) begin
        req_q <= 1'b1;
        if (!booted_q) begin
          pc_q     <= boot_addr_i;  // First command only
          booted_q <= 1'b1;
        end
      end
      if (req_q && instr_gnt_i) begin
        req_q  <= 1'b0;
        wait_q <= 1'b1;
      end
      if (wait_q && instr_rvalid_i) begin
        wait_q <= 1'b0;
        if (word_cnt_q == cnt_w'(`TILE_CMD_WORDS - 1)) begin
          word_cnt_q <= '0;
          done_q     <= 1'b1;
          pc_q       <= pc_q + addr_t'(4 * `TILE_CMD_WORDS);  // Next command
        end else begin
          word_cnt_q <= word_cnt_q + 1'b1;
          req_q      <= 1'b1;  // Next word of this command
        end
      end
    end
  end

  // Command buffer
  always_ff @(posedge clk) begin
    if (wait_q && instr_rvalid_i) cmd_q[word_cnt_q] <= instr_rdata_i;
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = pc_q + {word_cnt_q, 2'b00};
  assign fetch_done_o = done_q;

  // Field decode of the buffered command
  assign opcode_o = opcode_e'(cmd_q[0][`TILE_OP_MSB:`TILE_OP_LSB]);
  assign len_o    = cmd_q[0][`TILE_LEN_MSB:`TILE_LEN_LSB];
  assign exit_o   = cmd_q[0][`TILE_EXIT_W-1:0];
  assign a_base_o = cmd_q[1];
  assign b_base_o = cmd_q[2];
  assign d_base_o = cmd_q[3];

endmodule

/* hdl/tile_lsu.sv */
`timescale 1ns/10ps

`include "tile_defs.svh"

module tile_lsu import tile_pkg::*; (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  rd_a_start_i,
  input  logic  rd_b_start_i,
  input  logic  wr_start_i,
  input  len_t  idx_i,
  input  addr_t a_base_i,
  input  addr_t b_base_i,
  input  addr_t d_base_i,
  input  word_t wdata_i,
  output logic  data_req_o,
  output addr_t data_addr_o,
  output logic  data_we_o,
  output word_t data_wdata_o,
  input  logic  data_gnt_i,
  input  logic  data_rvalid_i,
  input  word_t data_rdata_i,
  output logic  op_done_o,
  output word_t a_word_o,
  output word_t b_word_o
);

  logic  req_q;
  logic  we_q;
  logic  wait_q;   // Read granted, data pending
  logic  sel_b_q;  // Read targets operand B
  addr_t base_q;   // Base of the current access
  word_t a_word_q;
  word_t b_word_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q   <= 1'b0;
      we_q    <= 1'b0;
      wait_q  <= 1'b0;
      sel_b_q <= 1'b0;
      base_q  <= '0;
    end else begin
      if (rd_a_start_i || rd_b_start_i || wr_start_i) begin
        req_q   <= 1'b1;
        we_q    <= wr_start_i;
        sel_b_q <= rd_b_start_i;
        base_q  <= wr_start_i   ? d_base_i :
                   rd_b_start_i ? b_base_i : a_base_i;
      end else if (req_q && data_gnt_i) begin
        req_q  <= 1'b0;
        we_q   <= 1'b0;
        wait_q <= !we_q;  // Writes get no response
      end
      if (wait_q && data_rvalid_i) wait_q <= 1'b0;
    end
  end

  // Operand holding registers
  always_ff @(posedge clk) begin
    if (wait_q && data_rvalid_i) begin
      if (sel_b_q) b_word_q <= data_rdata_i;
      else         a_word_q <= data_rdata_i;
    end
  end

  // Index stays put while a request is pending
  assign data_addr_o  = base_q + {idx_i, 2'b00};
  assign data_req_o   = req_q;
  assign data_we_o    = we_q;
  assign data_wdata_o = we_q ? wdata_i : '0;  // ALU result is stable during WR

  // Read done on rvalid, write done on grant
  assign op_done_o = (wait_q && data_rvalid_i) || (req_q && we_q && data_gnt_i);
  assign a_word_o  = a_word_q;
  assign b_word_o  = b_word_q;

endmodule

/* hdl/tile_alu_acc.sv */
`timescale 1ns/10ps

`include "tile_defs.svh"

module tile_alu_acc import tile_pkg::*; (
  input  logic    clk,
  input  logic    rst_n_i,
  input  logic    acc_clr_i,
  input  logic    acc_en_i,
  input  opcode_e opcode_i,
  input  word_t   a_i,
  input  word_t   b_i,
  output word_t   result_o
);

  word_t prod;   // Low half of the product only
  word_t acc_q;

  assign prod = a_i * b_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q <= '0;
    end else if (acc_clr_i) begin
      acc_q <= '0;
    end else if (acc_en_i) begin
      if (opcode_i == OP_DOT) acc_q <= acc_q + prod;  // Wraps at 32 bits
      else                    acc_q <= a_i + b_i;     // VADD element
    end
  end

  assign result_o = acc_q;

endmodule

/* hdl/mini_tile.sv */
`timescale 1ns/10ps

`include "tile_defs.svh"

module mini_tile import tile_pkg::*; (
  input  logic   clk,
  input  logic   rst_n_i,
  input  logic   fetch_enable_i,
  input  addr_t  boot_addr_i,
  // Instruction port
  output logic   instr_req_o,
  output addr_t  instr_addr_o,
  input  logic   instr_gnt_i,
  input  logic   instr_rvalid_i,
  input  word_t  instr_rdata_i,
  // Data port
  output logic   data_req_o,
  output addr_t  data_addr_o,
  output logic   data_we_o,
  output word_t  data_wdata_o,
  input  logic   data_gnt_i,
  input  logic   data_rvalid_i,
  input  word_t  data_rdata_i,
  // Status
  output logic   busy_o,
  output logic   core_sleep_o,
  output logic   eoc_o,
  output exit_t  exit_code_o,
  output cycle_t mcycle_o
);

  logic    fetch_start, fetch_done;
  logic    rd_a_start, rd_b_start, wr_start;
  logic    acc_clr, acc_en, cnt_clr, cnt_inc;
  logic    op_done, last_elem;
  opcode_e opcode;
  len_t    len, idx;
  addr_t   a_base, b_base, d_base;
  exit_t   exit_cmd;  // Exit field of the current command
  word_t   a_word, b_word, result;

  tile_ctrl_fsm u_ctrl (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .fetch_enable_i(fetch_enable_i),
    .fetch_done_i  (fetch_done),
    .op_done_i     (op_done),
    .last_elem_i   (last_elem),
    .opcode_i      (opcode),
    .exit_i        (exit_cmd),
    .fetch_start_o (fetch_start),
    .rd_a_start_o  (rd_a_start),
    .rd_b_start_o  (rd_b_start),
    .wr_start_o    (wr_start),
    .acc_clr_o     (acc_clr),
    .acc_en_o      (acc_en),
    .cnt_clr_o     (cnt_clr),
    .cnt_inc_o     (cnt_inc),
    .busy_o        (busy_o),
    .core_sleep_o  (core_sleep_o),
    .eoc_o         (eoc_o),
    .exit_code_o   (exit_code_o)
  );

  tile_step_counter u_cnt (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .cnt_clr_i  (cnt_clr),
    .cnt_inc_i  (cnt_inc),
    .len_i      (len),
    .idx_o      (idx),
    .last_elem_o(last_elem),
    .mcycle_o   (mcycle_o)
  );

  tile_fetch_unit u_fetch (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .boot_addr_i   (boot_addr_i),
    .fetch_start_i (fetch_start),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i),
    .fetch_done_o  (fetch_done),
    .opcode_o      (opcode),
    .len_o         (len),
    .a_base_o      (a_base),
    .b_base_o      (b_base),
    .d_base_o      (d_base),
    .exit_o        (exit_cmd)
  );

  tile_lsu u_lsu (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .rd_a_start_i (rd_a_start),
    .rd_b_start_i (rd_b_start),
    .wr_start_i   (wr_start),
    .idx_i        (idx),
    .a_base_i     (a_base),
    .b_base_i     (b_base),
    .d_base_i     (d_base),
    .wdata_i      (result),
    .data_req_o   (data_req_o),
    .data_addr_o  (data_addr_o),
    .data_we_o    (data_we_o),
    .data_wdata_o (data_wdata_o),
    .data_gnt_i   (data_gnt_i),
    .data_rvalid_i(data_rvalid_i),
    .data_rdata_i (data_rdata_i),
    .op_done_o    (op_done),
    .a_word_o     (a_word),
    .b_word_o     (b_word)
  );

  tile_alu_acc u_alu (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .acc_clr_i(acc_clr),
    .acc_en_i (acc_en),
    .opcode_i (opcode),
    .a_i      (a_word),
    .b_i      (b_word),
    .result_o (result)
  );

endmodule

/* sim/tile_vip.sv */
`timescale 1ns/10ps

module tile_vip import tile_pkg::*; (
  output logic  clk,
  output logic  rst_n_o,
  output logic  fetch_enable_o,
  output addr_t boot_addr_o,
  // Instruction memory side
  input  logic  instr_req_i,
  input  addr_t instr_addr_i,
  output logic  instr_gnt_o,
  output logic  instr_rvalid_o,
  output word_t instr_rdata_o,
  // Data memory side
  input  logic  data_req_i,
  input  addr_t data_addr_i,
  input  logic  data_we_i,
  input  word_t data_wdata_i,
  output logic  data_gnt_o,
  output logic  data_rvalid_o,
  output word_t data_rdata_o
);

  word_t       imem [256];    // 1 KiB of program
  word_t       dmem [1024];   // 4 KiB of data
  logic [31:0] lcg_q = 32'h52b0_a5e2;
  logic        i_fire, d_fire, d_we;  // Transfers of the cycle that just ended
  addr_t       i_addr, d_addr;

  // Shared LCG, the testbench draws its data from it too
  function automatic word_t next_rand();
    lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
    return lcg_q;
  endfunction

  // Roughly 30 percent of cycles stall
  function automatic logic grant_roll();
    word_t r;
    r = next_rand();
    return (r[31:16] % 100) >= 30;
  endfunction

  function automatic word_t fill_word(input addr_t a);
    return a ^ 32'h5A5A_5A5A;  // Unique per byte address
  endfunction

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  initial begin
    rst_n_o        = 1'b0;
    fetch_enable_o = 1'b0;
    boot_addr_o    = '0;
    instr_gnt_o    = 1'b0;
    instr_rvalid_o = 1'b0;
    instr_rdata_o  = '0;
    data_gnt_o     = 1'b0;
    data_rvalid_o  = 1'b0;
    data_rdata_o   = '0;
  end

  // Both memories in one process so the LCG order is fixed
  always begin
    @(negedge clk);  // Request and grant are settled here
    i_fire = (instr_req_i && instr_gnt_o) === 1'b1;
    i_addr = instr_addr_i;
    d_fire = (data_req_i && data_gnt_o) === 1'b1;
    d_we   = data_we_i;
    d_addr = data_addr_i;
    if (d_fire && d_we) dmem[d_addr[11:2]] = data_wdata_i;  // Write lands in its grant cycle
    @(posedge clk);
    #2;
    instr_rvalid_o = i_fire;  // One cycle after the grant
    instr_rdata_o  = i_fire ? imem[i_addr[9:2]] : '0;
    data_rvalid_o  = d_fire && !d_we;
    data_rdata_o   = (d_fire && !d_we) ? dmem[d_addr[11:2]] : '0;
    instr_gnt_o    = (instr_req_i === 1'b1) ? grant_roll() : 1'b0;
    data_gnt_o     = (data_req_i === 1'b1) ? grant_roll() : 1'b0;
  end

  task automatic apply_reset();
    @(posedge clk);
    #2;
    fetch_enable_o = 1'b0;
    rst_n_o        = 1'b0;
    repeat (5) @(posedge clk);
    #2 rst_n_o = 1'b1;
  endtask

  task automatic start(input addr_t boot);
    @(posedge clk);
    #2;
    boot_addr_o    = boot;
    fetch_enable_o = 1'b1;
  endtask

  task automatic clear_mem();
    foreach (imem[i]) imem[i] = fill_word(addr_t'(4 * i));  // Stray fetch decodes as illegal
    foreach (dmem[i]) dmem[i] = fill_word(addr_t'(4 * i));
  endtask

  task automatic load_instr(input addr_t addr, input word_t w);
    imem[addr[9:2]] = w;
  endtask

  task automatic load_data(input addr_t addr, input word_t w);
    dmem[addr[11:2]] = w;
  endtask

  function automatic word_t peek_data(input addr_t addr);
    return dmem[addr[11:2]];
  endfunction

endmodule

/* sim/tile_asserts.sv */
`timescale 1ns/10ps

module tile_asserts import tile_pkg::*; (
  input logic   clk,
  input logic   rst_n_i,
  input logic   fetch_enable_i,
  input logic   instr_req_o,
  input addr_t  instr_addr_o,
  input logic   instr_gnt_i,
  input logic   data_req_o,
  input addr_t  data_addr_o,
  input logic   data_we_o,
  input word_t  data_wdata_o,
  input logic   data_gnt_i,
  input logic   busy_o,
  input logic   eoc_o,
  input logic   core_sleep_o,
  input cycle_t mcycle_o
);

  int   fail_cnt = 0;  // Read by the testbench
  logic started_q;     // fetch_enable_i seen since reset

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) started_q <= 1'b0;
    else if (fetch_enable_i) started_q <= 1'b1;
  end

  // Request held with its address until granted
  instr_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else begin
      fail_cnt++;
      $error("instr request dropped or moved before its grant");
    end

  data_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o)
      && $stable(data_we_o) && $stable(data_wdata_o))
    else begin
      fail_cnt++;
      $error("data request dropped or changed before its grant");
    end

  // Quiet and asleep until the first fetch enable
  idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n_i)
    !started_q |-> !instr_req_o && !data_req_o && !eoc_o && !busy_o && core_sleep_o)
    else begin
      fail_cnt++;
      $error("tile active before fetch_enable_i");
    end

  // Any memory traffic means the tile is working
  busy_when_req: assert property (@(posedge clk) disable iff (!rst_n_i)
    instr_req_o || data_req_o |-> busy_o)
    else begin
      fail_cnt++;
      $error("memory request while busy_o is low");
    end

  // Parked after END, neither busy nor asleep
  parked_at_eoc: assert property (@(posedge clk) disable iff (!rst_n_i)
    eoc_o |-> !busy_o && !core_sleep_o)
    else begin
      fail_cnt++;
      $error("busy_o or core_sleep_o wrong while eoc_o is high");
    end

  mcycle_step: assert property (@(posedge clk) disable iff (!rst_n_i)
    1'b1 |=> mcycle_o == $past(mcycle_o) + 64'd1)
    else begin
      fail_cnt++;
      $error("mcycle_o did not advance by one");
    end

endmodule

/* sim/tile_tb.sv */
`timescale 1ns/10ps

`include "tile_defs.svh"

module tile_tb import tile_pkg::*; ();

  localparam int clk_period  = 20;
  localparam int total_elems = 20;  // 8 + 5 + 4 + 3 over all tests
  localparam int wd_cycles   = 200 * total_elems + 2000;

  // Nets named after the DUT ports
  logic   clk, rst_n_i, fetch_enable_i;
  addr_t  boot_addr_i;
  logic   instr_req_o, instr_gnt_i, instr_rvalid_i;
  addr_t  instr_addr_o;
  word_t  instr_rdata_i;
  logic   data_req_o, data_we_o, data_gnt_i, data_rvalid_i;
  addr_t  data_addr_o;
  word_t  data_wdata_o, data_rdata_i;
  logic   busy_o, core_sleep_o, eoc_o;
  exit_t  exit_code_o;
  cycle_t mcycle_o;

  int    errors;
  int    tests_run;
  int    tests_failed;
  int    total;
  addr_t pc;                // Next command slot
  word_t va [$];
  word_t vb [$];
  word_t exp_mem [addr_t];  // Expected data words by byte address

  tile_vip u_vip (
    .clk           (clk),
    .rst_n_o       (rst_n_i),
    .fetch_enable_o(fetch_enable_i),
    .boot_addr_o   (boot_addr_i),
    .instr_req_i   (instr_req_o),
    .instr_addr_i  (instr_addr_o),
    .instr_gnt_o   (instr_gnt_i),
    .instr_rvalid_o(instr_rvalid_i),
    .instr_rdata_o (instr_rdata_i),
    .data_req_i    (data_req_o),
    .data_addr_i   (data_addr_o),
    .data_we_i     (data_we_o),
    .data_wdata_i  (data_wdata_o),
    .data_gnt_o    (data_gnt_i),
    .data_rvalid_o (data_rvalid_i),
    .data_rdata_o  (data_rdata_i)
  );

  mini_tile u_dut (.*);

  bind mini_tile tile_asserts u_asserts (.*);

  function automatic int total_fails();
    return errors + u_dut.u_asserts.fail_cnt;
  endfunction

  task automatic check_word(input string sig, input word_t exp, input word_t got);
    assert (got === exp)
    else begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, sig, got, exp);
      errors++;
    end
  endtask

  // Four command words at pc
  task automatic put_cmd(input logic [3:0] op, input int len, input addr_t a, b, d,
                         input exit_t code);
    word_t w0;
    w0 = '0;
    w0[`TILE_OP_MSB:`TILE_OP_LSB]   = op;
    w0[`TILE_LEN_MSB:`TILE_LEN_LSB] = len_t'(len);
    w0[`TILE_EXIT_W-1:0]            = code;
    u_vip.load_instr(pc, w0);
    u_vip.load_instr(pc + 4, a);
    u_vip.load_instr(pc + 8, b);
    u_vip.load_instr(pc + 12, d);
    pc = pc + 16;
  endtask

  task automatic gen_vecs(input addr_t a, input addr_t b, input int n);
    va = {};
    vb = {};
    for (int i = 0; i < n; i++) begin
      va.push_back(u_vip.next_rand());
      vb.push_back(u_vip.next_rand());
      u_vip.load_data(a + 4 * i, va[i]);
      u_vip.load_data(b + 4 * i, vb[i]);
    end
  endtask

  task automatic expect_dot(input addr_t a, input addr_t b, input addr_t d, input int n);
    word_t sum;
    gen_vecs(a, b, n);
    sum = '0;
    for (int i = 0; i < n; i++) sum = sum + va[i] * vb[i];  // Low 32 bits, wraps
    exp_mem[d] = sum;
  endtask

  task automatic expect_vadd(input addr_t a, input addr_t b, input addr_t d, input int n);
    gen_vecs(a, b, n);
    for (int i = 0; i < n; i++) exp_mem[d + 4 * i] = va[i] + vb[i];
  endtask

  // Word that no command may write
  task automatic guard(input addr_t addr);
    word_t w;
    w = u_vip.next_rand();
    u_vip.load_data(addr, w);
    exp_mem[addr] = w;
  endtask

  task automatic prepare();
    u_vip.apply_reset();
    u_vip.clear_mem();
    exp_mem.delete();
  endtask

  task automatic run_test(input string name, input addr_t boot, input exit_t exp_exit,
                          input int elems);
    int cycles;
    int fails_before;
    fails_before = total_fails();
    tests_run++;
    u_vip.start(boot);
    cycles = 0;
    while (!eoc_o && cycles < 200 * elems + 500) begin
      @(negedge clk);
      cycles++;
    end
    if (!eoc_o) begin
      $display("Error at %0t ns: %s never raised eoc_o", $time, name);
      errors++;
    end else begin
      check_word("exit_code_o", word_t'(exp_exit), word_t'(exit_code_o));
      foreach (exp_mem[a]) check_word($sformatf("dmem[%h]", a), exp_mem[a], u_vip.peek_data(a));
    end
    if (total_fails() != fails_before) tests_failed++;
    $display("Test %-12s %s, %0d cycles", name,
             (total_fails() == fails_before) ? "ok" : "failed", cycles);
  endtask

  initial begin
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;

    prepare();
    pc = 32'h40;
    put_cmd(OP_DOT, 8, 32'h100, 32'h200, 32'h300, '0);
    put_cmd(OP_END, 0, '0, '0, '0, 16'h0001);
    expect_dot(32'h100, 32'h200, 32'h300, 8);
    run_test("dot_len8", 32'h40, 16'h0001, 8);

    prepare();
    pc = 32'h40;
    put_cmd(OP_VADD, 5, 32'h500, 32'h600, 32'h700, '0);
    put_cmd(OP_END, 0, '0, '0, '0, 16'h0002);
    expect_vadd(32'h500, 32'h600, 32'h700, 5);
    guard(32'h714);  // Just past the fifth sum
    run_test("vadd_len5", 32'h40, 16'h0002, 5);

    prepare();
    pc = 32'h80;  // Other boot address
    put_cmd(OP_DOT, 4, 32'h100, 32'h200, 32'h300, '0);
    put_cmd(OP_VADD, 3, 32'h400, 32'h500, 32'h600, '0);
    put_cmd(OP_END, 0, '0, '0, '0, 16'h0042);
    expect_dot(32'h100, 32'h200, 32'h300, 4);
    expect_vadd(32'h400, 32'h500, 32'h600, 3);
    run_test("program", 32'h80, 16'h0042, 7);

    prepare();
    pc = 32'h20;
    put_cmd(4'h7, 3, 32'h100, 32'h200, 32'h300, '0);
    guard(32'h300);  // Illegal command writes nothing
    run_test("illegal_op", 32'h20, 16'hDEAD, 1);

    total = total_fails();
    $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, errors, u_dut.u_asserts.fail_cnt);
    if (total == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog over the whole run
  initial begin
    #(wd_cycles * clk_period);
    $display("Timeout: run did not finish within %0d cycles", wd_cycles);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+hdl
hdl/tile_pkg.sv
hdl/tile_ctrl_fsm.sv
hdl/tile_step_counter.sv
hdl/tile_fetch_unit.sv
hdl/tile_lsu.sv
hdl/tile_alu_acc.sv
hdl/mini_tile.sv
sim/tile_vip.sv
sim/tile_asserts.sv
sim/tile_tb.sv

/* Bender.yml */
package:
  name: mini_tile

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/tile_pkg.sv
      - hdl/tile_ctrl_fsm.sv
      - hdl/tile_step_counter.sv
      - hdl/tile_fetch_unit.sv
      - hdl/tile_lsu.sv
      - hdl/tile_alu_acc.sv
      - hdl/mini_tile.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/tile_vip.sv
      - sim/tile_asserts.sv
      - sim/tile_tb.sv
